//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_legv8_core
FILELIST  = verilog.f
LOG       = sim.log
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- control_unit.sv
`timescale 1ns/100ps

module control_unit (
    input  logic  clk,
    input  logic  rst,
    core_if.ctrl  cif,
    output logic  halted
);
    import legv8_pkg::*;

    logic [31:0]   ir;         // Instruction register
    logic [1:0]    state;
    control_word_t d_cw;
    control_word_t i_cw;
    control_word_t sel_cw;
    logic [63:0]   d_k;
    logic [63:0]   i_k;
    logic          is_d;
    logic          is_i;
    logic          mem_op;

    // Both decoders look at the same word
    d_decoder i_d_decoder (
        .instr (ir),
        .cw    (d_cw),
        .k     (d_k)
    );

    i_decoder i_i_decoder (
        .instr (ir),
        .cw    (i_cw),
        .k     (i_k)
    );

    // Opcode class
    assign is_d = (ir[31:21] == OP_STUR) || (ir[31:21] == OP_LDUR);
    assign is_i = ir[31:22] inside {OP_ADDI, OP_ANDI, OP_ORRI, OP_EORI};

    always_comb begin
        sel_cw            = '0;
        sel_cw.pc_fs      = PC_FS_HOLD;   // Halt word, nothing moves
        sel_cw.next_state = ST_EXECUTE;
        if (is_d) begin
            sel_cw = d_cw;
        end else if (is_i) begin
            sel_cw = i_cw;
        end
    end

    assign mem_op = sel_cw.ram_en | sel_cw.ram_w; // Needs a bus cycle

    // Word only live in execute
    assign cif.cw    = (state == ST_EXECUTE) ? sel_cw : control_word_t'('0);
    assign cif.k     = is_d ? d_k : i_k;
    assign cif.fetch = (state == ST_FETCH);

    // Load on fetch ack
    always_ff @(posedge clk) begin
        if (cif.fetch && cif.bus_done) begin
            ir <= cif.instr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_FETCH;
            halted <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (cif.bus_done) begin
                        state <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE: begin
                    if (!is_d && !is_i) begin
                        halted <= 1'b1; // Parked here until reset
                    end else if (!mem_op || cif.bus_done) begin
                        state <= sel_cw.next_state; // ALU ops leave after one cycle
                    end
                end
                default: state <= ST_FETCH;
            endcase
        end
    end

endmodule

//--- core_if.sv
`timescale 1ns/100ps

interface core_if;
    import legv8_pkg::*;

    control_word_t cw;        // Active word, all zero during fetch
    logic [63:0]   k;         // Zero-extended immediate
    logic          fetch;     // FSM in ST_FETCH
    logic [31:0]   instr;     // Low word of read data
    logic          bus_done;  // Ack seen on open Wishbone cycle

    // Control side
    modport ctrl (
        output cw,
        output k,
        output fetch,
        input  instr,
        input  bus_done
    );

    // Datapath side
    modport dp (
        input  cw,
        input  k,
        input  fetch,
        output instr,
        output bus_done
    );

endinterface

//--- d_decoder.sv
`timescale 1ns/100ps

module d_decoder (
    input  logic [31:0]               instr,
    output legv8_pkg::control_word_t  cw,
    output logic [63:0]               k
);
    import legv8_pkg::*;

    logic [10:0] op;
    logic [8:0]  dt_address;
    logic [1:0]  op2;        // Always 00 for STUR/LDUR
    logic [4:0]  rn;
    logic [4:0]  rt;
    logic        is_load;

    assign {op, dt_address, op2, rn, rt} = instr;
    assign is_load = op[1]; // 0 store, 1 load

    assign k = {55'd0, dt_address}; // Unsigned byte offset

    always_comb begin
        cw            = '0;
        cw.alu_en     = 1'b0;                 // ALU only forms the address
        cw.alu_bs     = 1'b1;                 // Rn + K
        cw.alu_fs     = {ALU_ADD, 2'b00};
        cw.rf_b_en    = ~is_load;             // Rt onto bus for stores
        cw.rf_sa      = rn;
        cw.rf_sb      = rt;
        cw.rf_da      = rt;
        cw.rf_w       = is_load;
        cw.ram_en     = is_load;              // Read data onto bus
        cw.ram_w      = ~is_load;
        cw.pc_en      = 1'b0;
        cw.pc_fs      = PC_FS_INC;
        cw.pc_is      = 1'b0;
        cw.status_ld  = 1'b0;
        cw.next_state = ST_FETCH;
        if (op2 != 2'b00) begin
            cw.rf_w = 1'b0; // Not a plain unscaled access
        end
    end

endmodule

//--- datapath.sv
`timescale 1ns/100ps

module datapath (
    input  logic        clk,
    input  logic        rst,
    core_if.dp          dif,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [63:0] wb_adr,
    output logic [63:0] wb_dat_w,
    input  logic [63:0] wb_dat_r,
    input  logic        wb_ack
);
    import legv8_pkg::*;

    logic [63:0] pc;
    logic [63:0] regs [0:30];   // X0..X30, XZR not stored
    logic [63:0] rf_a;
    logic [63:0] rf_b;
    logic [63:0] alu_a;
    logic [63:0] alu_b;
    logic [63:0] alu_y;
    logic [63:0] data_bus;
    logic        cyc_q;         // Wishbone cycle open
    logic        mem_req;
    logic        exec_done;

    // Register file reads, 31 is zero
    assign rf_a = (dif.cw.rf_sa == XZR) ? 64'd0 : regs[dif.cw.rf_sa];
    assign rf_b = (dif.cw.rf_sb == XZR) ? 64'd0 : regs[dif.cw.rf_sb];

    // ALU with optional operand inversion
    always_comb begin
        alu_a = dif.cw.alu_fs[0] ? ~rf_a : rf_a;
        alu_b = dif.cw.alu_bs ? dif.k : rf_b;
        if (dif.cw.alu_fs[1]) begin
            alu_b = ~alu_b;
        end
        case (dif.cw.alu_fs[4:2])
            ALU_AND: alu_y = alu_a & alu_b;
            ALU_OR:  alu_y = alu_a | alu_b;
            ALU_ADD: alu_y = alu_a + alu_b + {63'd0, dif.cw.alu_fs[1]}; // ~b + 1 subtracts
            ALU_XOR: alu_y = alu_a ^ alu_b;
            default: alu_y = 64'd0;  // Shifts not built
        endcase
    end

    // Data bus, one source at a time
    always_comb begin
        if (dif.cw.alu_en) begin
            data_bus = alu_y;
        end else if (dif.cw.rf_b_en) begin
            data_bus = rf_b;
        end else if (dif.cw.ram_en) begin
            data_bus = wb_dat_r;
        end else begin
            data_bus = 64'd0;
        end
    end

    assign mem_req   = dif.cw.ram_en | dif.cw.ram_w;
    assign exec_done = ~dif.fetch & (mem_req ? dif.bus_done : 1'b1);

    // Handshake back to control
    assign dif.bus_done = cyc_q & wb_ack;
    assign dif.instr    = wb_dat_r[31:0];   // Instructions in low word

    // Write back at end of execute
    always_ff @(posedge clk) begin
        if (exec_done && dif.cw.rf_w && dif.cw.rf_da != XZR) begin
            regs[dif.cw.rf_da] <= data_bus;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= 64'd0;
        end else if (exec_done && dif.cw.pc_fs == PC_FS_INC) begin
            pc <= pc + PC_INCR;
        end
    end

    // Wishbone classic master
    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_q <= 1'b0;
            wb_we <= 1'b0;
        end else if (cyc_q) begin
            if (wb_ack) begin
                cyc_q <= 1'b0;  // Drop in the cycle after ack
                wb_we <= 1'b0;
            end
        end else if (dif.fetch) begin
            cyc_q <= 1'b1;
            wb_we <= 1'b0;
        end else if (mem_req) begin
            cyc_q <= 1'b1;
            wb_we <= dif.cw.ram_w;
        end
    end

    // Address and write data held for the whole cycle
    always_ff @(posedge clk) begin
        if (!cyc_q) begin
            wb_adr   <= dif.fetch ? pc : alu_y;   // PC or Rn + K
            wb_dat_w <= data_bus;                 // Rt for stores
        end
    end

    assign wb_cyc = cyc_q;
    assign wb_stb = cyc_q; // Rises and falls with cyc

endmodule

//--- i_decoder.sv
`timescale 1ns/100ps

module i_decoder (
    input  logic [31:0]               instr,
    output legv8_pkg::control_word_t  cw,
    output logic [63:0]               k
);
    import legv8_pkg::*;

    logic [9:0]  op;
    logic [11:0] imm12;
    logic [4:0]  rn;
    logic [4:0]  rd;
    logic [2:0]  func;

    assign {op, imm12, rn, rd} = instr;

    // Immediate zero-extended, no bitmask expansion for the logic ops
    assign k = {52'd0, imm12};

    // Opcode to ALU function
    always_comb begin
        case (op)
            OP_ADDI: func = ALU_ADD;
            OP_ANDI: func = ALU_AND;
            OP_ORRI: func = ALU_OR;
            OP_EORI: func = ALU_XOR;
            default: func = ALU_ADD; // Never selected by control
        endcase
    end

    always_comb begin
        cw            = '0;
        cw.alu_en     = 1'b1;             // Result onto data bus
        cw.alu_bs     = 1'b1;             // K into B
        cw.alu_fs     = {func, 2'b00};    // No inversions
        cw.rf_b_en    = 1'b0;
        cw.rf_sa      = rn;
        cw.rf_sb      = rd;               // Unused read port
        cw.rf_da      = rd;
        cw.rf_w       = 1'b1;
        cw.ram_en     = 1'b0;
        cw.ram_w      = 1'b0;
        cw.pc_en      = 1'b0;
        cw.pc_fs      = PC_FS_INC;
        cw.pc_is      = 1'b0;
        cw.status_ld  = 1'b0;
        cw.next_state = ST_FETCH;
    end

endmodule

//--- legv8_core.sv
`timescale 1ns/100ps

module legv8_core (
    input  logic        clk,
    input  logic        rst,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [63:0] wb_adr,
    output logic [63:0] wb_dat_w,
    input  logic [63:0] wb_dat_r,
    input  logic        wb_ack,
    output logic        halted
);

    core_if cif ();

    // Decode, IR and FSM
    control_unit i_control_unit (
        .clk    (clk),
        .rst    (rst),
        .cif    (cif.ctrl),
        .halted (halted)
    );

    // Registers, ALU, PC and bus master
    datapath i_datapath (
        .clk      (clk),
        .rst      (rst),
        .dif      (cif.dp),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

//--- legv8_pkg.sv
package legv8_pkg;

    // 33-bit control word, field order as in the decoder tables
    typedef struct packed {
        logic       alu_en;     // ALU drives data bus
        logic       alu_bs;     // ALU B select, 1 = K
        logic [4:0] alu_fs;     // Function in [4:2], ~b in [1], ~a in [0]
        logic       rf_b_en;    // Register B drives data bus
        logic [4:0] rf_sa;      // Read address A
        logic [4:0] rf_sb;      // Read address B
        logic [4:0] rf_da;      // Write address
        logic       rf_w;       // Register file write
        logic       ram_en;     // RAM drives data bus, i.e. a load
        logic       ram_w;      // RAM write, i.e. a store
        logic       pc_en;      // PC drives data bus
        logic [1:0] pc_fs;      // PC function
        logic       pc_is;      // PC input select, no branches here
        logic       status_ld;  // No flags in this core
        logic [1:0] next_state;
    } control_word_t;

    // FSM state codes
    localparam logic [1:0] ST_FETCH   = 2'b00;
    localparam logic [1:0] ST_EXECUTE = 2'b01;

    // ALU function, upper three bits of alu_fs
    localparam logic [2:0] ALU_AND = 3'b000;
    localparam logic [2:0] ALU_OR  = 3'b001;
    localparam logic [2:0] ALU_ADD = 3'b010;
    localparam logic [2:0] ALU_XOR = 3'b011;

    // PC function select
    localparam logic [1:0] PC_FS_HOLD = 2'b00;
    localparam logic [1:0] PC_FS_INC  = 2'b01; // PC + 4

    // D-format, 64-bit size only
    localparam logic [10:0] OP_STUR = 11'b111_1100_0000;
    localparam logic [10:0] OP_LDUR = 11'b111_1100_0010;

    // I-format, instr[31:22]
    localparam logic [9:0] OP_ADDI = 10'b10_0100_0100;
    localparam logic [9:0] OP_ANDI = 10'b10_0100_1000;
    localparam logic [9:0] OP_ORRI = 10'b10_1100_1000;
    localparam logic [9:0] OP_EORI = 10'b11_0100_1000;

    localparam logic [4:0]  XZR     = 5'd31; // Always reads zero
    localparam logic [63:0] PC_INCR = 64'd4;

endpackage

//--- tb_legv8_core.sv
`timescale 1ns/100ps

module tb_legv8_core;

    // ISA opcodes
    localparam logic [9:0]  ADDI = 10'b10_0100_0100;
    localparam logic [9:0]  ANDI = 10'b10_0100_1000;
    localparam logic [9:0]  ORRI = 10'b10_1100_1000;
    localparam logic [9:0]  EORI = 10'b11_0100_1000;
    localparam logic [10:0] STUR = 11'b111_1100_0000;
    localparam logic [10:0] LDUR = 11'b111_1100_0010;
    localparam logic [31:0] HALT = 32'hD503_201F;     // Any opcode outside the subset
    localparam logic [63:0] DATA_BASE = 64'h100;      // Program below, data above
    localparam int PROG_LEN = 22;
    localparam int N_STORES = 10;
    localparam int LIMIT    = 20 * PROG_LEN + 100;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [63:0] wb_adr;
    logic [63:0] wb_dat_w;
    logic [63:0] wb_dat_r;
    logic        wb_ack;
    logic        halted;

    logic [31:0] prog [PROG_LEN];       // Instruction words
    logic [63:0] data_adr [2];          // Preloaded data
    logic [63:0] data_val [2];
    logic [63:0] exp_adr [N_STORES];    // Stores in program order
    logic [63:0] exp_dat [N_STORES];
    logic [63:0] mem [logic [63:0]];    // Sparse memory model
    logic [63:0] exp_pc = 64'd0;
    logic [63:0] hold_adr;
    logic [63:0] hold_dat;
    logic        hold_we;
    logic        busy;
    logic [1:0]  wait_cnt;
    logic        b1;
    logic        b0;
    logic [31:0] lfsr = 32'd86060;
    int          n_exp = 0;
    int          store_idx = 0;
    int          fetch_count = 0;
    int          data_errors = 0;
    int          bus_errors = 0;
    int          cycles = 0;

    legv8_core i_legv8_core (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .halted   (halted)
    );

    always #20 clk = ~clk;   // 40 ns period

    function automatic logic [31:0] enc_i(input logic [9:0] op, input logic [11:0] imm,
                                          input logic [4:0] rn, input logic [4:0] rd);
        return {op, imm, rn, rd};
    endfunction

    function automatic logic [31:0] enc_d(input logic [10:0] op, input logic [8:0] off,
                                          input logic [4:0] rn, input logic [4:0] rt);
        return {op, off, 2'b00, rn, rt};
    endfunction

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic next_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic add_store(input logic [63:0] adr, input logic [63:0] dat);
        exp_adr[n_exp] = adr;
        exp_dat[n_exp] = dat;
        n_exp++;
    endtask

    // Program and expected stores, x[] tracks the architectural registers
    task automatic build_tables();
        logic [63:0] x [32];
        data_adr[0] = 64'h180;
        data_val[0] = 64'hDEAD_BEEF_0123_4567;
        data_adr[1] = 64'h188;
        data_val[1] = 64'h8000_0000_0000_0001;
        x[31] = 64'd0;                                      // XZR
        prog[0]  = enc_i(ADDI, 12'h100, 5'd31, 5'd2);
        x[2] = x[31] + 64'h100;
        prog[1]  = enc_i(ADDI, 12'h5A5, 5'd31, 5'd1);
        x[1] = x[31] + 64'h5A5;
        prog[2]  = enc_d(STUR, 9'h000, 5'd2, 5'd1);
        add_store(x[2] + 64'h0, x[1]);
        prog[3]  = enc_i(ANDI, 12'h0F0, 5'd1, 5'd3);
        x[3] = x[1] & 64'h0F0;
        prog[4]  = enc_d(STUR, 9'h008, 5'd2, 5'd3);
        add_store(x[2] + 64'h8, x[3]);
        prog[5]  = enc_i(ORRI, 12'h30F, 5'd3, 5'd4);
        x[4] = x[3] | 64'h30F;
        prog[6]  = enc_d(STUR, 9'h010, 5'd2, 5'd4);
        add_store(x[2] + 64'h10, x[4]);
        prog[7]  = enc_i(EORI, 12'hFFF, 5'd4, 5'd5);
        x[5] = x[4] ^ 64'hFFF;
        prog[8]  = enc_d(STUR, 9'h018, 5'd2, 5'd5);
        add_store(x[2] + 64'h18, x[5]);
        prog[9]  = enc_i(ADDI, 12'hFFF, 5'd5, 5'd6);
        x[6] = x[5] + 64'hFFF;
        prog[10] = enc_d(STUR, 9'h020, 5'd2, 5'd6);
        add_store(x[2] + 64'h20, x[6]);
        prog[11] = enc_d(LDUR, 9'h080, 5'd2, 5'd7);         // From data_adr[0]
        x[7] = data_val[0];
        prog[12] = enc_d(LDUR, 9'h088, 5'd2, 5'd8);
        x[8] = data_val[1];
        prog[13] = enc_d(STUR, 9'h040, 5'd2, 5'd7);
        add_store(x[2] + 64'h40, x[7]);
        prog[14] = enc_d(STUR, 9'h048, 5'd2, 5'd8);
        add_store(x[2] + 64'h48, x[8]);
        prog[15] = enc_i(ADDI, 12'h001, 5'd7, 5'd9);
        x[9] = x[7] + 64'd1;
        prog[16] = enc_d(STUR, 9'h050, 5'd2, 5'd9);
        add_store(x[2] + 64'h50, x[9]);
        prog[17] = enc_i(ADDI, 12'h077, 5'd1, 5'd31);       // Lost in XZR
        prog[18] = enc_d(STUR, 9'h058, 5'd2, 5'd31);
        add_store(x[2] + 64'h58, x[31]);
        prog[19] = enc_d(LDUR, 9'h080, 5'd2, 5'd31);        // Load into XZR, also lost
        prog[20] = enc_d(STUR, 9'h1F8, 5'd2, 5'd31);        // Top of 9-bit offset
        add_store(x[2] + 64'h1F8, x[31]);
        prog[21] = HALT;
    endtask

    task automatic check_low(input string name, input logic value);
        assert (value === 1'b0) else begin
            $display("error %t %s: expected 0, actual %b", $time, name, value);
            bus_errors++;
        end
    endtask

    task automatic check_store();
        assert (store_idx < N_STORES) else begin
            $display("store %0d at %t is beyond the expected list", store_idx, $time);
            bus_errors++;
        end
        if (store_idx < N_STORES) begin
            assert (wb_adr == exp_adr[store_idx]) else begin
                $display("error %t wb_adr: expected %h, actual %h",
                         $time, exp_adr[store_idx], wb_adr);
                data_errors++;
            end
            assert (wb_dat_w == exp_dat[store_idx]) else begin
                $display("error %t wb_dat_w: expected %h, actual %h",
                         $time, exp_dat[store_idx], wb_dat_w);
                data_errors++;
            end
        end
        store_idx++;
    endtask

    // Last cycle of a Wishbone transfer
    task automatic serve_cycle();
        if (wb_we || wb_adr >= DATA_BASE) begin
            assert (wb_adr[2:0] == 3'd0) else begin
                $display("data access at %h, %t, is not 8-byte aligned", wb_adr, $time);
                bus_errors++;
            end
        end
        if (wb_we) begin
            mem[wb_adr] = wb_dat_w;
            check_store();
        end else begin
            if (wb_adr < DATA_BASE) begin                   // Instruction fetch
                assert (wb_adr == exp_pc) else begin
                    $display("error %t wb_adr: expected %h, actual %h", $time, exp_pc, wb_adr);
                    data_errors++;
                end
                exp_pc = exp_pc + 64'd4;
                fetch_count++;
            end
            wb_dat_r = mem.exists(wb_adr) ? mem[wb_adr] : 64'd0;
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d data, %0d bus; stores %0d of %0d; fetches %0d",
                 data_errors, bus_errors, store_idx, N_STORES, fetch_count);
    endtask

    // Wishbone slave, 0 to 3 wait states per transfer
    initial begin
        wb_ack   = 1'b0;
        wb_dat_r = 64'd0;
        busy     = 1'b0;
        wait_cnt = 2'd0;
        forever begin
            @(posedge clk);
            #2;
            assert (wb_stb === wb_cyc) else begin
                $display("error %t wb_stb: expected %b, actual %b", $time, wb_cyc, wb_stb);
                bus_errors++;
            end
            if (wb_ack) begin
                wb_ack = 1'b0;                  // Master saw ack at this edge
            end else if (wb_cyc) begin
                if (!busy) begin
                    busy     = 1'b1;
                    hold_adr = wb_adr;
                    hold_we  = wb_we;
                    hold_dat = wb_dat_w;
                    next_bit(b1);
                    next_bit(b0);
                    wait_cnt = {b1, b0};
                end else begin
                    assert ({wb_adr, wb_we, wb_dat_w} == {hold_adr, hold_we, hold_dat}) else begin
                        $display("address, we or write data moved during a wait, %t", $time);
                        bus_errors++;
                    end
                end
                if (wait_cnt == 2'd0) begin
                    serve_cycle();
                    busy   = 1'b0;
                    wb_ack = 1'b1;
                end else begin
                    wait_cnt = wait_cnt - 2'd1;
                end
            end
        end
    end

    // Run limit from the program length
    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, core did not halt", cycles);
        print_counts();
        $display("Test FAILED");
        $finish;
    end

    initial begin
        $timeformat(-9, 1, " ns", 0);
        clk = 1'b0;
        rst = 1'b1;
        build_tables();
        for (int i = 0; i < PROG_LEN; i++) begin
            mem[64'(4 * i)] = {32'd0, prog[i]};     // Low word only
        end
        for (int i = 0; i < 2; i++) begin
            mem[data_adr[i]] = data_val[i];
        end
        repeat (2) @(posedge clk);
        #2;
        check_low("wb_cyc", wb_cyc);
        check_low("wb_stb", wb_stb);
        check_low("wb_we", wb_we);
        check_low("halted", halted);
        rst = 1'b0;
        @(posedge clk);
        #2;
        assert (wb_cyc === 1'b1 && wb_adr === 64'd0) else begin
            $display("no fetch from address 0 in the first cycle after reset");
            bus_errors++;
        end
        while (halted !== 1'b1) begin
            @(posedge clk);
            #2;
        end
        repeat (10) begin
            @(posedge clk);
            #2;
            assert (wb_cyc === 1'b0) else begin
                $display("bus cycle at %h started after halt, %t", wb_adr, $time);
                bus_errors++;
            end
        end
        assert (store_idx == N_STORES) else begin
            $display("saw %0d stores instead of %0d", store_idx, N_STORES);
            bus_errors++;
        end
        assert (fetch_count == PROG_LEN) else begin
            $display("saw %0d fetches instead of %0d", fetch_count, PROG_LEN);
            bus_errors++;
        end
        print_counts();
        if (data_errors + bus_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
legv8_pkg.sv
core_if.sv
d_decoder.sv
i_decoder.sv
control_unit.sv
datapath.sv
legv8_core.sv
tb_legv8_core.sv
